// ==== riscv_pkg.sv ====
package riscv_pkg;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////////////////////////

  // Instruction bits 6..2, the low two bits are always 2'b11 for RV32/64
  typedef enum logic [4:0] {
    op_lui       = 5'b01101,
    op_auipc     = 5'b00101,
    op_jal       = 5'b11011,
    op_jalr      = 5'b11001,
    op_branch    = 5'b11000,
    op_op_imm    = 5'b00100,
    op_op        = 5'b01100,
    op_op_imm_32 = 5'b00110,
    op_op_32     = 5'b01110,
    op_system    = 5'b11100
  } opcode_t;

  //////////////////////////////////////////////////////////////////////
  // Function codes
  //////////////////////////////////////////////////////////////////////

  // Integer func3, shared by OP and OP-IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // SYSTEM func3 for the Zicsr forms
  // 3'b000 and 3'b100 are not CSR accesses
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  // func7
  // Alt selects sub over add and arithmetic over logical right shift
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  //////////////////////////////////////////////////////////////////////
  // Branch conditions
  //////////////////////////////////////////////////////////////////////

  // Branch func3, 3'b010 and 3'b011 are reserved
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_t;

  //////////////////////////////////////////////////////////////////////
  // Machine-mode CSR addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mtval    = 12'h343;

endpackage

// ==== riscv_alu.sv ====
module riscv_alu
  import riscv_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] id_pc,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  output logic            alu_bubble,
  output logic [XLEN-1:0] alu_r,
  output logic [11:0]     csr_addr,
  output logic            csr_we,
  output logic [XLEN-1:0] csr_wval,
  input  logic [XLEN-1:0] csr_rval
);

  localparam int SBITS = $clog2(XLEN);

  // Full-width integer operation
  function automatic logic [XLEN-1:0] int_op(input logic [2:0] f3, input logic sub,
                                            input logic sra, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [SBITS-1:0] sh;
    logic [XLEN-1:0]  r;
    sh = b[SBITS-1:0];
    case (f3)
      f3_add:  r = sub ? a - b : a + b;
      f3_sll:  r = a << sh;
      f3_slt:  r = XLEN'($signed(a) < $signed(b));
      f3_sltu: r = XLEN'(a < b);
      f3_xor:  r = a ^ b;
      f3_sr:   r = sra ? XLEN'($signed(a) >>> sh) : a >> sh;
      f3_or:   r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // RV64 word operation, 32-bit result sign-extended to XLEN
  function automatic logic [XLEN-1:0] word_op(input logic [2:0] f3, input logic sub,
                                             input logic sra, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (f3)
      f3_add:  r = sub ? a - b : a + b;
      f3_sll:  r = a << sh;
      default: r = sra ? 32'($signed(a) >>> sh) : a >> sh;
    endcase
    return XLEN'(signed'(r));
  endfunction

  opcode_t         opcode;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic            alt;
  logic            is_csr;
  logic [XLEN-1:0] zimm;
  logic [XLEN-1:0] r_nxt;
  logic            legal;

  // Instruction fields
  assign opcode = opcode_t'(id_instr[6:2]);
  assign func3  = id_instr[14:12];
  assign func7  = id_instr[31:25];
  assign alt    = (func7 == f7_alt);

  //////////////////////////////////////////////////////////////////////
  // Result and decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    r_nxt = '0;
    legal = 1'b1;
    case (opcode)
      // lui arrives with op_a zero, auipc with op_a holding pc
      op_lui, op_auipc: r_nxt = op_a + op_b;
      // Link value
      op_jal, op_jalr:  r_nxt = id_pc + XLEN'(4);
      // Immediate shifts take the arithmetic bit from instruction bit 30
      op_op_imm:        r_nxt = int_op(func3, 1'b0, id_instr[30], op_a, op_b);
      op_op: begin
        legal = (func7 == f7_base) || (alt && (func3 == f3_add || func3 == f3_sr));
        r_nxt = int_op(func3, alt, alt, op_a, op_b);
      end
      op_op_imm_32: begin
        legal = (XLEN == 64) && (func3 inside {f3_add, f3_sll, f3_sr});
        r_nxt = word_op(func3, 1'b0, id_instr[30], op_a[31:0], op_b[31:0]);
      end
      op_op_32: begin
        legal = (XLEN == 64) &&
                ((func3 == f3_sll && func7 == f7_base) ||
                 ((func3 == f3_add || func3 == f3_sr) && (func7 == f7_base || alt)));
        r_nxt = word_op(func3, alt, alt, op_a[31:0], op_b[31:0]);
      end
      // CSR forms hand back the old value
      op_system: begin
        legal = is_csr;
        r_nxt = csr_rval;
      end
      default: legal = 1'b0;
    endcase
  end

  // Bubble also flags anything this unit does not execute
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      alu_bubble <= 1'b1;
    end else if (!ex_stall) begin
      alu_bubble <= id_bubble | ~legal;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      alu_r <= r_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CSR read-modify-write
  //////////////////////////////////////////////////////////////////////

  assign csr_addr = id_instr[31:20];
  assign zimm     = {{(XLEN-5){1'b0}}, op_b[4:0]};
  assign is_csr   = (opcode == op_system) && (func3 != 3'b000) && (func3 != 3'b100);

  always_comb begin
    csr_we   = 1'b0;
    csr_wval = '0;
    if (!id_bubble && is_csr) begin
      case (func3)
        f3_csrrw: begin
          csr_we   = 1'b1;
          csr_wval = op_a;
        end
        f3_csrrwi: begin
          csr_we   = |zimm;
          csr_wval = zimm;
        end
        // Set and clear only write with a nonzero source
        f3_csrrs: begin
          csr_we   = |op_a;
          csr_wval = csr_rval | op_a;
        end
        f3_csrrsi: begin
          csr_we   = |zimm;
          csr_wval = csr_rval | zimm;
        end
        f3_csrrc: begin
          csr_we   = |op_a;
          csr_wval = csr_rval & ~op_a;
        end
        default: begin
          csr_we   = |zimm;
          csr_wval = csr_rval & ~zimm;
        end
      endcase
    end
  end

endmodule

// ==== riscv_bu.sv ====
module riscv_bu
  import riscv_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] id_pc,
  input  logic [XLEN-1:0] id_imm,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  output logic            bu_bubble,
  output logic            bu_taken,
  output logic [XLEN-1:0] bu_target
);

  opcode_t         opcode;
  br_cond_t        cond;
  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_ltu;
  logic            taken_nxt;
  logic [XLEN-1:0] target_nxt;
  logic            handled;

  assign opcode = opcode_t'(id_instr[6:2]);
  assign cond   = br_cond_t'(id_instr[14:12]);

  // Signed and unsigned comparators
  assign cmp_eq  = (op_a == op_b);
  assign cmp_lt  = ($signed(op_a) < $signed(op_b));
  assign cmp_ltu = (op_a < op_b);

  //////////////////////////////////////////////////////////////////////
  // Decision and target
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    handled    = 1'b1;
    taken_nxt  = 1'b0;
    target_nxt = id_pc + id_imm;
    case (opcode)
      op_branch: begin
        case (cond)
          br_eq:   taken_nxt = cmp_eq;
          br_ne:   taken_nxt = ~cmp_eq;
          br_lt:   taken_nxt = cmp_lt;
          br_ge:   taken_nxt = ~cmp_lt;
          br_ltu:  taken_nxt = cmp_ltu;
          br_geu:  taken_nxt = ~cmp_ltu;
          // Reserved conditions
          default: handled = 1'b0;
        endcase
      end
      op_jal:  taken_nxt = 1'b1;
      // Register-relative target with bit 0 forced low
      op_jalr: begin
        taken_nxt  = 1'b1;
        target_nxt = (op_a + id_imm) & ~XLEN'(1);
      end
      default: handled = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_bubble <= 1'b1;
      bu_taken  <= 1'b0;
    end else if (!ex_stall) begin
      bu_bubble <= id_bubble | ~handled;
      bu_taken  <= taken_nxt;
    end
  end

  // Jump or branch target
  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      bu_target <= target_nxt;
    end
  end

endmodule

// ==== riscv_csr_file.sv ====
module riscv_csr_file
  import riscv_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic [11:0]     csr_addr,
  input  logic            csr_we,
  input  logic [XLEN-1:0] csr_wval,
  output logic [XLEN-1:0] csr_rval
);

  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtval;
  logic [XLEN-1:0] mtvec;
  logic            wr;
  logic [XLEN-1:0] wval_align;

  // A stalled instruction is reissued, so its write waits
  assign wr = csr_we & ~ex_stall;

  // Instruction alignment for mepc and mtvec
  assign wval_align = {csr_wval[XLEN-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mscratch <= '0;
      mepc     <= '0;
      mtval    <= '0;
      mtvec    <= '0;
    end else if (wr) begin
      case (csr_addr)
        csr_mscratch: mscratch <= csr_wval;
        csr_mepc:     mepc     <= wval_align;
        csr_mtval:    mtval    <= csr_wval;
        csr_mtvec:    mtvec    <= wval_align;
        // Unknown address, write dropped
        default: ;
      endcase
    end
  end

  // Read port
  always_comb begin
    case (csr_addr)
      csr_mscratch: csr_rval = mscratch;
      csr_mepc:     csr_rval = mepc;
      csr_mtval:    csr_rval = mtval;
      csr_mtvec:    csr_rval = mtvec;
      default:      csr_rval = '0;
    endcase
  end

endmodule

// ==== riscv_ex_result.sv ====
module riscv_ex_result #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic            alu_bubble,
  input  logic [XLEN-1:0] alu_r,
  input  logic            bu_bubble,
  input  logic            bu_taken,
  input  logic [XLEN-1:0] bu_target,
  output logic            wb_we,
  output logic [4:0]      wb_rd,
  output logic [XLEN-1:0] wb_r,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic            ex_illegal
);

  logic       ex_valid;
  logic [4:0] rd;

  // Tracks the instruction now held in the unit registers
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_valid <= 1'b0;
    end else if (!ex_stall) begin
      ex_valid <= ~id_bubble;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      rd <= id_instr[11:7];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Merge
  //////////////////////////////////////////////////////////////////////

  // x0 is never written
  assign wb_we       = ex_valid & ~alu_bubble & (|rd);
  assign wb_rd       = rd;
  assign wb_r        = alu_r;
  assign redirect    = ~bu_bubble & bu_taken;
  assign redirect_pc = bu_target;
  // Neither unit claimed a valid instruction
  assign ex_illegal  = ex_valid & alu_bubble & bu_bubble;

endmodule

// ==== riscv_execution.sv ====
module riscv_execution #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  logic [XLEN-1:0] id_pc,
  input  logic [XLEN-1:0] id_imm,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  output logic            wb_we,
  output logic [4:0]      wb_rd,
  output logic [XLEN-1:0] wb_r,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic            ex_illegal
);

  // ALU to CSR file
  logic [11:0]     csr_addr;
  logic            csr_we;
  logic [XLEN-1:0] csr_wval;
  logic [XLEN-1:0] csr_rval;

  // Unit registers to result stage
  logic            alu_bubble;
  logic [XLEN-1:0] alu_r;
  logic            bu_bubble;
  logic            bu_taken;
  logic [XLEN-1:0] bu_target;

  //////////////////////////////////////////////////////////////////////
  // Execution units
  //////////////////////////////////////////////////////////////////////

  riscv_alu #(.XLEN(XLEN)) alu_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_bubble(id_bubble), .id_instr(id_instr), .id_pc(id_pc),
    .op_a(op_a), .op_b(op_b),
    .alu_bubble(alu_bubble), .alu_r(alu_r),
    .csr_addr(csr_addr), .csr_we(csr_we), .csr_wval(csr_wval), .csr_rval(csr_rval)
  );

  riscv_bu #(.XLEN(XLEN)) bu_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_bubble(id_bubble), .id_instr(id_instr), .id_pc(id_pc), .id_imm(id_imm),
    .op_a(op_a), .op_b(op_b),
    .bu_bubble(bu_bubble), .bu_taken(bu_taken), .bu_target(bu_target)
  );

  // Machine-mode CSRs
  riscv_csr_file #(.XLEN(XLEN)) csr_file_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .csr_addr(csr_addr), .csr_we(csr_we), .csr_wval(csr_wval), .csr_rval(csr_rval)
  );

  riscv_ex_result #(.XLEN(XLEN)) ex_result_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_bubble(id_bubble), .id_instr(id_instr),
    .alu_bubble(alu_bubble), .alu_r(alu_r),
    .bu_bubble(bu_bubble), .bu_taken(bu_taken), .bu_target(bu_target),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_r(wb_r),
    .redirect(redirect), .redirect_pc(redirect_pc), .ex_illegal(ex_illegal)
  );

endmodule

// ==== riscv_execution_tb.sv ====
module riscv_execution_tb
  import riscv_pkg::*;
();

  localparam int XLEN = 64;
  // About 1200 cycles of tests
  localparam int cycle_limit = 3000;

  logic            clk;
  logic            rstn;
  logic            ex_stall;
  logic            id_bubble;
  logic [31:0]     id_instr;
  logic [XLEN-1:0] id_pc;
  logic [XLEN-1:0] id_imm;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            wb_we;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_r;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic            ex_illegal;

  // Reference model state
  logic [63:0] csr_model [4];
  logic        exp_we;
  logic [4:0]  exp_rd;
  logic [63:0] exp_r;
  logic        exp_redir;
  logic [63:0] exp_pc;
  logic        exp_ill;
  logic        held;
  logic [63:0] last_r;
  logic [63:0] last_pc;
  int          mismatches;
  int          checks;
  int          cycles;

  riscv_execution #(.XLEN(XLEN)) riscv_execution_i (
    .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
    .id_bubble(id_bubble), .id_instr(id_instr), .id_pc(id_pc), .id_imm(id_imm),
    .op_a(op_a), .op_b(op_b),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_r(wb_r),
    .redirect(redirect), .redirect_pc(redirect_pc), .ex_illegal(ex_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Encoding and operand helpers
  ////////////////////////////////////////////////////////////////////////

  // R-type layout with rs1 and rs2 left zero since operands come in directly
  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] opc);
    return {f7, 10'd0, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [11:0] addr, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {addr, 5'd0, f3, rd, op_system, 2'b11};
  endfunction

  // Edge values mixed with random ones
  function automatic logic [63:0] rand_operand();
    case ($urandom % 5)
      0:       return '0;
      1:       return '1;
      2:       return 64'h8000_0000_0000_0000;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////

  // alt picks sub and arithmetic right shift
  function automatic logic [63:0] int_result(input logic [2:0] f3, input logic alt,
                                             input logic [63:0] a, input logic [63:0] b);
    case (f3)
      f3_add:  return alt ? a - b : a + b;
      f3_sll:  return a << b[5:0];
      f3_slt:  return {63'd0, $signed(a) < $signed(b)};
      f3_sltu: return {63'd0, a < b};
      f3_xor:  return a ^ b;
      f3_sr:   return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // Word forms give a 32-bit result then sign extension
  function automatic logic [63:0] word_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      f3_add:  r = alt ? a - b : a + b;
      f3_sll:  r = a << b[4:0];
      default: r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    endcase
    return {{32{r[31]}}, r};
  endfunction

  function automatic logic branch_holds(input logic [2:0] f3, input logic [63:0] a,
                                        input logic [63:0] b);
    case (f3)
      br_eq:   return a == b;
      br_ne:   return a != b;
      br_lt:   return $signed(a) < $signed(b);
      br_ge:   return $signed(a) >= $signed(b);
      br_ltu:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Expected outputs for the instruction accepted at this edge
  task automatic predict();
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic        alt;
    logic        alu_ok;
    logic        bu_ok;
    logic        taken;
    logic        hit;
    logic [1:0]  idx;
    logic [63:0] r;
    logic [63:0] tgt;
    logic [63:0] src;
    logic [63:0] nv;
    opc    = id_instr[6:2];
    f3     = id_instr[14:12];
    alt    = id_instr[30];
    alu_ok = 1'b1;
    bu_ok  = 1'b0;
    taken  = 1'b0;
    hit    = 1'b1;
    idx    = 2'd0;
    r      = '0;
    tgt    = id_pc + id_imm;
    case (opc)
      op_lui, op_auipc: r = op_a + op_b;
      // Link is always pc plus 4
      op_jal, op_jalr: begin
        r     = id_pc + 64'd4;
        bu_ok = 1'b1;
        taken = 1'b1;
        if (opc == op_jalr) tgt = (op_a + id_imm) & ~64'd1;
      end
      op_branch: begin
        alu_ok = 1'b0;
        bu_ok  = 1'b1;
        taken  = branch_holds(f3, op_a, op_b);
      end
      op_op_imm:    r = int_result(f3, alt && f3 == f3_sr, op_a, op_b);
      op_op:        r = int_result(f3, alt, op_a, op_b);
      op_op_imm_32: r = word_result(f3, alt && f3 == f3_sr, op_a[31:0], op_b[31:0]);
      op_op_32:     r = word_result(f3, alt, op_a[31:0], op_b[31:0]);
      op_system: begin
        // func3 000 and 100 are no CSR access
        alu_ok = (f3[1:0] != 2'b00);
        case (id_instr[31:20])
          csr_mscratch: idx = 2'd0;
          csr_mepc:     idx = 2'd1;
          csr_mtval:    idx = 2'd2;
          csr_mtvec:    idx = 2'd3;
          default:      hit = 1'b0;
        endcase
        r   = hit ? csr_model[idx] : '0;
        src = f3[2] ? {59'd0, op_b[4:0]} : op_a;
        case (f3[1:0])
          2'b01:   nv = src;
          2'b10:   nv = r | src;
          default: nv = r & ~src;
        endcase
        // Odd index is mepc or mtvec which stay word aligned
        if (alu_ok && hit && (f3 == f3_csrrw || src != '0)) begin
          csr_model[idx] = idx[0] ? {nv[63:2], 2'b00} : nv;
        end
      end
      default: alu_ok = 1'b0;
    endcase
    exp_we    <= alu_ok && (id_instr[11:7] != 5'd0);
    exp_rd    <= id_instr[11:7];
    exp_r     <= r;
    exp_redir <= bu_ok && taken;
    exp_pc    <= tgt;
    exp_ill   <= !alu_ok && !bu_ok;
  endtask

  always @(posedge clk) begin
    held <= rstn && ex_stall;
    if (!rstn) begin
      exp_we    <= 1'b0;
      exp_redir <= 1'b0;
      exp_ill   <= 1'b0;
      for (int i = 0; i < 4; i++) csr_model[i] = '0;
    end else if (!ex_stall) begin
      if (id_bubble) begin
        exp_we    <= 1'b0;
        exp_redir <= 1'b0;
        exp_ill   <= 1'b0;
      end else begin
        predict();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
    mismatches++;
  endtask

  // Mid-cycle when outputs have settled since the last rising edge
  always @(negedge clk) begin
    if (rstn) begin
      checks++;
      assert (wb_we == exp_we) else report_mismatch("wb_we", 64'(wb_we), 64'(exp_we));
      assert (redirect == exp_redir)
        else report_mismatch("redirect", 64'(redirect), 64'(exp_redir));
      assert (ex_illegal == exp_ill)
        else report_mismatch("ex_illegal", 64'(ex_illegal), 64'(exp_ill));
      if (exp_we) begin
        assert (wb_rd == exp_rd) else report_mismatch("wb_rd", 64'(wb_rd), 64'(exp_rd));
        assert (wb_r == exp_r) else report_mismatch("wb_r", wb_r, exp_r);
      end
      if (exp_redir) begin
        assert (redirect_pc == exp_pc) else report_mismatch("redirect_pc", redirect_pc, exp_pc);
      end
      // Data outputs frozen across a stalled edge
      if (held) begin
        assert (wb_r === last_r) else report_mismatch("wb_r under stall", wb_r, last_r);
        assert (redirect_pc === last_pc)
          else report_mismatch("redirect_pc under stall", redirect_pc, last_pc);
      end
      last_r  <= wb_r;
      last_pc <= redirect_pc;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////

  // One instruction accepted at the next edge
  task automatic issue(input logic [31:0] instr, input logic [63:0] a, input logic [63:0] b);
    @(posedge clk);
    ex_stall  <= 1'b0;
    id_bubble <= 1'b0;
    id_instr  <= instr;
    op_a      <= a;
    op_b      <= b;
    id_pc     <= {$urandom, $urandom} & ~64'd3;
    id_imm    <= {$urandom, $urandom};
  endtask

  // Junk instruction bits under a bubble
  task automatic insert_bubble();
    @(posedge clk);
    ex_stall  <= 1'b0;
    id_bubble <= 1'b1;
    id_instr  <= $urandom;
  endtask

  task automatic random_alu(input int n);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  opc;
    logic [63:0] a;
    repeat (n) begin
      f3 = 3'($urandom);
      f7 = f7_base;
      a  = rand_operand();
      case ($urandom % 5)
        0: begin
          opc = op_op;
          if ((f3 == f3_add || f3 == f3_sr) && $urandom % 2 == 1) f7 = f7_alt;
        end
        1: begin
          opc = op_op_imm;
          if (f3 == f3_sr && $urandom % 2 == 1) f7 = f7_alt;
        end
        2, 3: begin
          opc = ($urandom % 2 == 1) ? op_op_32 : op_op_imm_32;
          case ($urandom % 3)
            0:       f3 = f3_add;
            1:       f3 = f3_sll;
            default: f3 = f3_sr;
          endcase
          // subw only in the register form
          if ($urandom % 2 == 1 && (f3 == f3_sr || (f3 == f3_add && opc == op_op_32))) begin
            f7 = f7_alt;
          end
        end
        default: begin
          opc = ($urandom % 2 == 1) ? op_lui : op_auipc;
          if (opc == op_lui) a = '0;
        end
      endcase
      issue(enc(f7, f3, 5'($urandom), opc), a, rand_operand());
      if ($urandom % 8 == 0) insert_bubble();
    end
  endtask

  task automatic branch_jump(input int n);
    logic [2:0]  f3;
    logic [63:0] a;
    repeat (n) begin
      f3 = 3'($urandom);
      // Reserved 010 and 011 folded onto the unsigned pair
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;
      a = rand_operand();
      issue(enc(7'($urandom), f3, 5'($urandom), op_branch), a,
            ($urandom % 3 == 0) ? a : rand_operand());
      if ($urandom % 4 == 0) begin
        issue(enc(7'($urandom), 3'($urandom), 5'($urandom),
                  ($urandom % 2 == 1) ? op_jal : op_jalr), {$urandom, $urandom}, '0);
      end
    end
  endtask

  // Every access read back by a zero-source csrrs
  task automatic csr_access(input int n);
    logic [11:0] addr;
    logic [2:0]  f3;
    repeat (n) begin
      case ($urandom % 5)
        0:       addr = csr_mscratch;
        1:       addr = csr_mepc;
        2:       addr = csr_mtval;
        3:       addr = csr_mtvec;
        default: addr = 12'h7c0;
      endcase
      f3 = 3'($urandom);
      if (f3[1:0] == 2'b00) f3[1:0] = 2'b01;
      issue(enc_csr(addr, f3, 5'($urandom)), ($urandom % 3 == 0) ? '0 : rand_operand(),
            ($urandom % 3 == 0) ? '0 : {$urandom, $urandom});
      issue(enc_csr(addr, f3_csrrs, 5'd1), '0, '0);
    end
  endtask

  // Stalled csrrw must not land before the readback
  task automatic stall_hold(input int n);
    int len;
    repeat (n) begin
      issue(enc(f7_base, f3_add, 5'd3, op_op), rand_operand(), rand_operand());
      len = 1 + $urandom % 6;
      repeat (len) begin
        @(posedge clk);
        ex_stall  <= 1'b1;
        id_bubble <= 1'b0;
        id_instr  <= enc_csr(csr_mscratch, f3_csrrw, 5'd2);
        op_a      <= {$urandom, $urandom};
      end
      issue(enc_csr(csr_mscratch, f3_csrrs, 5'd4), '0, '0);
    end
  endtask

  // Load, store, fence, op-fp and ecall
  task automatic unsupported(input int n);
    repeat (n) begin
      case ($urandom % 5)
        0:       issue(enc(7'd0, 3'($urandom), 5'd5, 5'b00000), '1, '1);
        1:       issue(enc(7'd0, 3'($urandom), 5'd5, 5'b01000), '1, '1);
        2:       issue(enc(7'd0, 3'($urandom), 5'd5, 5'b00011), '1, '1);
        3:       issue(enc(7'd0, 3'($urandom), 5'd5, 5'b10100), '1, '1);
        default: issue(enc_csr(12'h000, 3'b000, 5'd0), '0, '0);
      endcase
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the test sequence did not complete", cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    void'($urandom(25));
    mismatches = 0;
    checks     = 0;
    rstn      <= 1'b0;
    ex_stall  <= 1'b0;
    id_bubble <= 1'b1;
    id_instr  <= '0;
    id_pc     <= '0;
    id_imm    <= '0;
    op_a      <= '0;
    op_b      <= '0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    random_alu(600);
    branch_jump(120);
    csr_access(150);
    stall_hold(10);
    unsupported(12);
    insert_bubble();
    insert_bubble();
    // Past the negedge that checks the last bubble
    @(posedge clk);
    $display("errors: %0d mismatches in %0d checks", mismatches, checks);
    if (mismatches == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
riscv_pkg.sv
riscv_alu.sv
riscv_bu.sv
riscv_csr_file.sv
riscv_ex_result.sv
riscv_execution.sv
riscv_execution_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module riscv_execution_tb \
  -f vlog.f -o riscv_execution_tb
./obj_dir/riscv_execution_tb > sim.log
cat sim.log
if grep -q "Checks failed" sim.log; then
  exit 1
fi
